// File: hw/eval_defines.svh
`ifndef EVAL_DEFINES_SVH
`define EVAL_DEFINES_SVH

`define EVAL_WIDTH     24                 // Signed score width
`define PIECE_WIDTH    4                  // Bits per square
`define SQUARE_COUNT   64
`define BOARD_WIDTH    (`SQUARE_COUNT * `PIECE_WIDTH)

`define PHASE_MAX      62                 // Phase cap, also the blend divisor
`define PHASE_RECIP    16912              // floor(2^20 / 62)
`define PHASE_SHIFT    20

// Piece type codes in the low three bits of a square
`define EMPTY          0
`define PAWN           1
`define KNIGHT         2
`define BISHOP         3
`define ROOK           4
`define QUEEN          5
`define KING           6
`define COLOR_BIT      3                  // Set for black

`define MG_PAWN        82
`define MG_KNIGHT      337
`define MG_BISHOP      365
`define MG_ROOK        477
`define MG_QUEEN       1025
`define MG_KING        0

`define EG_PAWN        94
`define EG_KNIGHT      281
`define EG_BISHOP      297
`define EG_ROOK        512
`define EG_QUEEN       936
`define EG_KING        0

`endif

// File: hw/chess_pkg.sv
`default_nettype none

`include "eval_defines.svh"

package chess_pkg;

   // One square: color in the top bit, piece type below it
   typedef logic [`PIECE_WIDTH-1:0] piece_t;

   // Square n sits in bits 4n upward, square 0 at the bottom
   typedef logic [`BOARD_WIDTH-1:0] board_t;

   // One bit per square, set when a piece stands there
   typedef logic [`SQUARE_COUNT-1:0] occupancy_t;

endpackage

`default_nettype wire

// File: hw/eval_pkg.sv
`default_nettype none

`include "eval_defines.svh"

package eval_pkg;

   typedef logic [4:0] piece_count_t;            // One piece type, one side
   typedef logic [6:0] square_count_t;           // Up to 64 occupied squares
   typedef logic [5:0] phase_t;                  // 0 to 62

   typedef logic signed [`EVAL_WIDTH-1:0] score_t;
   typedef logic signed [47:0] blend_t;          // Wide taper products
   typedef logic signed [31:0] material_t;

   // Result stage: waiting, blend pipeline busy, result held
   typedef enum logic [1:0] {
      IDLE,
      BLEND,
      HOLD
   } result_state_t;

endpackage

`default_nettype wire

// File: hw/board_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "eval_defines.svh"

module board_decode
   (
   input  wire                          clk,
   input  wire                          reset,
   input  wire                          board_valid,
   input  wire chess_pkg::board_t       board_in,
   input  wire                          done,
   output logic                         counts_valid,
   output eval_pkg::piece_count_t       white_pawns,
   output eval_pkg::piece_count_t       white_knights,
   output eval_pkg::piece_count_t       white_bishops,
   output eval_pkg::piece_count_t       white_rooks,
   output eval_pkg::piece_count_t       white_queens,
   output eval_pkg::piece_count_t       black_pawns,
   output eval_pkg::piece_count_t       black_knights,
   output eval_pkg::piece_count_t       black_bishops,
   output eval_pkg::piece_count_t       black_rooks,
   output eval_pkg::piece_count_t       black_queens,
   output eval_pkg::phase_t             phase
   );

   import chess_pkg::*;
   import eval_pkg::*;

   logic          board_valid_r;
   logic          busy;                         // One board in flight
   logic          board_loaded;                 // Holding register is fresh
   logic          start;
   board_t        board;
   occupancy_t    occupied;
   square_count_t occupied_count;
   piece_count_t  white_count [`PAWN:`QUEEN];
   piece_count_t  black_count [`PAWN:`QUEEN];

   // Rising edge only, and never while a result is outstanding
   assign start = board_valid && !board_valid_r && !busy;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         board_valid_r <= 1'b0;
         busy          <= 1'b0;
         board_loaded  <= 1'b0;
         counts_valid  <= 1'b0;
      end
      else
      begin
         board_valid_r <= board_valid;
         board_loaded  <= start;
         counts_valid  <= board_loaded;
         if (start)
            busy <= 1'b1;
         else if (done)
            busy <= 1'b0;                       // Released by clear_eval
      end
   end

   always_ff @(posedge clk)
   begin
      if (start)
         board <= board_in;                     // Flopped for timing
   end

   // Type code 7 is not a piece, so it counts as empty
   always_comb
   begin
      piece_t piece;
      occupied_count = '0;
      for (int t = `PAWN; t <= `QUEEN; t++)
      begin
         white_count[t] = '0;
         black_count[t] = '0;
      end
      for (int sq = 0; sq < `SQUARE_COUNT; sq++)
      begin
         piece = board[sq*`PIECE_WIDTH +: `PIECE_WIDTH];
         occupied[sq] = (piece[`COLOR_BIT-1:0] != `EMPTY) && (piece[`COLOR_BIT-1:0] <= `KING);
         occupied_count = occupied_count + square_count_t'(occupied[sq]);
         if (piece[`COLOR_BIT-1:0] >= `PAWN && piece[`COLOR_BIT-1:0] <= `QUEEN)
         begin
            if (piece[`COLOR_BIT])
               black_count[piece[`COLOR_BIT-1:0]] = black_count[piece[`COLOR_BIT-1:0]] + 1'b1;
            else
               white_count[piece[`COLOR_BIT-1:0]] = white_count[piece[`COLOR_BIT-1:0]] + 1'b1;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (board_loaded)
      begin
         white_pawns   <= white_count[`PAWN];
         white_knights <= white_count[`KNIGHT];
         white_bishops <= white_count[`BISHOP];
         white_rooks   <= white_count[`ROOK];
         white_queens  <= white_count[`QUEEN];
         black_pawns   <= black_count[`PAWN];
         black_knights <= black_count[`KNIGHT];
         black_bishops <= black_count[`BISHOP];
         black_rooks   <= black_count[`ROOK];
         black_queens  <= black_count[`QUEEN];
         phase <= (occupied_count > `PHASE_MAX) ? phase_t'(`PHASE_MAX) : phase_t'(occupied_count);
      end
   end

endmodule

`default_nettype wire

// File: hw/material_execute.sv
`timescale 1ns/1ps
`default_nettype none

`include "eval_defines.svh"

module material_execute
   (
   input  wire                          clk,
   input  wire                          reset,
   input  wire                          counts_valid,
   input  wire eval_pkg::piece_count_t  white_pawns,
   input  wire eval_pkg::piece_count_t  white_knights,
   input  wire eval_pkg::piece_count_t  white_bishops,
   input  wire eval_pkg::piece_count_t  white_rooks,
   input  wire eval_pkg::piece_count_t  white_queens,
   input  wire eval_pkg::piece_count_t  black_pawns,
   input  wire eval_pkg::piece_count_t  black_knights,
   input  wire eval_pkg::piece_count_t  black_bishops,
   input  wire eval_pkg::piece_count_t  black_rooks,
   input  wire eval_pkg::piece_count_t  black_queens,
   input  wire eval_pkg::phase_t        phase,
   output logic                         sums_valid,
   output eval_pkg::score_t             eval_mg,
   output eval_pkg::score_t             eval_eg,
   output eval_pkg::phase_t             phase_out,
   output eval_pkg::material_t          material,
   output logic                         insufficient_material
   );

   import eval_pkg::*;

   localparam int MG_VALUE [`PAWN:`QUEEN] = '{`MG_PAWN, `MG_KNIGHT, `MG_BISHOP, `MG_ROOK,
                                             `MG_QUEEN};
   localparam int EG_VALUE [`PAWN:`QUEEN] = '{`EG_PAWN, `EG_KNIGHT, `EG_BISHOP, `EG_ROOK,
                                             `EG_QUEEN};

   piece_count_t white_count [`PAWN:`QUEEN];
   piece_count_t black_count [`PAWN:`QUEEN];
   score_t       mg_sum;
   score_t       eg_sum;
   logic [5:0]   white_minors;                  // Knights plus bishops
   logic [5:0]   black_minors;
   logic         no_majors_or_pawns;

   assign white_count = '{white_pawns, white_knights, white_bishops, white_rooks, white_queens};
   assign black_count = '{black_pawns, black_knights, black_bishops, black_rooks, black_queens};

   // White minus black, weighted per piece type
   always_comb
   begin
      score_t diff;
      mg_sum = '0;
      eg_sum = '0;
      for (int t = `PAWN; t <= `QUEEN; t++)
      begin
         diff   = score_t'(white_count[t]) - score_t'(black_count[t]);
         mg_sum = mg_sum + diff * score_t'(MG_VALUE[t]);
         eg_sum = eg_sum + diff * score_t'(EG_VALUE[t]);
      end
   end

   assign white_minors = 6'(white_knights) + 6'(white_bishops);
   assign black_minors = 6'(black_knights) + 6'(black_bishops);
   assign no_majors_or_pawns = (white_pawns == '0) && (black_pawns == '0) &&
                               (white_rooks == '0) && (black_rooks == '0) &&
                               (white_queens == '0) && (black_queens == '0);

   always_ff @(posedge clk)
   begin
      if (reset)
         sums_valid <= 1'b0;
      else
         sums_valid <= counts_valid;
   end

   always_ff @(posedge clk)
   begin
      if (counts_valid)
      begin
         eval_mg   <= mg_sum;
         eval_eg   <= eg_sum;
         phase_out <= phase;
         material  <= material_t'(mg_sum);      // Sign-extended midgame sum
         insufficient_material <= no_majors_or_pawns && (white_minors <= 6'd1) &&
                                  (black_minors <= 6'd1);
      end
   end

endmodule

`default_nettype wire

// File: hw/taper_result.sv
`timescale 1ns/1ps
`default_nettype none

`include "eval_defines.svh"

module taper_result
   (
   input  wire                          clk,
   input  wire                          reset,
   input  wire                          sums_valid,
   input  wire eval_pkg::score_t        eval_mg,
   input  wire eval_pkg::score_t        eval_eg,
   input  wire eval_pkg::phase_t        phase,
   input  wire eval_pkg::material_t     material_in,
   input  wire                          insufficient_in,
   input  wire                          clear_eval,
   output eval_pkg::score_t             eval,
   output logic                         eval_valid,
   output eval_pkg::material_t          material,
   output logic                         insufficient_material,
   output logic                         done
   );

   import eval_pkg::*;

   result_state_t state;
   logic [2:0]    stage_valid;                  // Valid for stages 1 to 3
   phase_t        eg_weight;
   blend_t        mg_prod;
   blend_t        eg_prod;
   blend_t        blend_sum;
   blend_t        scaled;
   blend_t        rounded;
   score_t        eval_next;

   assign eg_weight = phase_t'(`PHASE_MAX) - phase;

   // Bias negatives so the shift truncates toward zero like a signed divide
   assign rounded = scaled + (scaled[$bits(blend_t)-1] ?
                              blend_t'((1 << `PHASE_SHIFT) - 1) : blend_t'(0));
   assign eval_next = score_t'(rounded >>> `PHASE_SHIFT);

   // (mg * phase + eg * (62 - phase)) / 62, the divide done by reciprocal
   always_ff @(posedge clk)
   begin
      mg_prod   <= blend_t'(eval_mg) * blend_t'(phase);
      eg_prod   <= blend_t'(eval_eg) * blend_t'(eg_weight);
      blend_sum <= mg_prod + eg_prod;
      scaled    <= blend_sum * blend_t'(`PHASE_RECIP);
      if (stage_valid[2])
         eval <= eval_next;
      if (sums_valid)
      begin
         material              <= material_in;
         insufficient_material <= insufficient_in;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state       <= IDLE;
         stage_valid <= '0;
         eval_valid  <= 1'b0;
         done        <= 1'b0;
      end
      else
      begin
         stage_valid <= {stage_valid[1:0], sums_valid};
         done        <= 1'b0;
         case (state)
            IDLE:
               if (sums_valid)
                  state <= BLEND;
            BLEND:
               if (stage_valid[2])
               begin
                  state      <= HOLD;
                  eval_valid <= 1'b1;            // Lands with the stage 4 result
               end
            HOLD:
               if (clear_eval)
               begin
                  state      <= IDLE;
                  eval_valid <= 1'b0;
                  done       <= 1'b1;            // Frees the decode stage
               end
            default:
               state <= IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: hw/evaluate.sv
`timescale 1ns/1ps
`default_nettype none

module evaluate
   (
   input  wire                          clk,
   input  wire                          reset,
   input  wire                          board_valid,
   input  wire chess_pkg::board_t       board_in,
   input  wire                          clear_eval,
   output eval_pkg::score_t             eval,
   output logic                         eval_valid,
   output eval_pkg::material_t          material,
   output logic                         insufficient_material
   );

   import eval_pkg::*;

   logic         counts_valid;
   logic         sums_valid;
   logic         done;                          // Result cleared, accept next board
   piece_count_t white_pawns, white_knights, white_bishops, white_rooks, white_queens;
   piece_count_t black_pawns, black_knights, black_bishops, black_rooks, black_queens;
   phase_t       phase;
   phase_t       sums_phase;
   score_t       eval_mg;
   score_t       eval_eg;
   material_t    sums_material;
   logic         sums_insufficient;

   board_decode u_decode (
      .clk(clk), .reset(reset), .board_valid(board_valid), .board_in(board_in), .done(done),
      .counts_valid(counts_valid),
      .white_pawns(white_pawns), .white_knights(white_knights), .white_bishops(white_bishops),
      .white_rooks(white_rooks), .white_queens(white_queens),
      .black_pawns(black_pawns), .black_knights(black_knights), .black_bishops(black_bishops),
      .black_rooks(black_rooks), .black_queens(black_queens),
      .phase(phase));

   material_execute u_execute (
      .clk(clk), .reset(reset), .counts_valid(counts_valid),
      .white_pawns(white_pawns), .white_knights(white_knights), .white_bishops(white_bishops),
      .white_rooks(white_rooks), .white_queens(white_queens),
      .black_pawns(black_pawns), .black_knights(black_knights), .black_bishops(black_bishops),
      .black_rooks(black_rooks), .black_queens(black_queens),
      .phase(phase),
      .sums_valid(sums_valid), .eval_mg(eval_mg), .eval_eg(eval_eg), .phase_out(sums_phase),
      .material(sums_material), .insufficient_material(sums_insufficient));

   taper_result u_result (
      .clk(clk), .reset(reset), .sums_valid(sums_valid),
      .eval_mg(eval_mg), .eval_eg(eval_eg), .phase(sums_phase),
      .material_in(sums_material), .insufficient_in(sums_insufficient),
      .clear_eval(clear_eval),
      .eval(eval), .eval_valid(eval_valid), .material(material),
      .insufficient_material(insufficient_material), .done(done));

endmodule

`default_nettype wire

// File: testbench/evaluate_checker.sv
`timescale 1ns/1ps
`default_nettype none

module evaluate_checker
   (
   input  wire                          clk,
   input  wire                          reset,
   input  wire                          clear_eval,
   input  wire                          eval_valid,
   input  wire eval_pkg::score_t        eval
   );

   int failures = 0;                            // Failed assertion count

   reset_clears_valid: assert property (@(posedge clk) reset |=> !eval_valid)
      else
      begin
         failures++;
         $error("eval_valid high in the cycle after reset");
      end

   // Result must not move while it is on display
   eval_stable: assert property (@(posedge clk) disable iff (reset)
      eval_valid |=> !eval_valid || $stable(eval))
      else
      begin
         failures++;
         $error("eval changed while eval_valid stayed high");
      end

   valid_held: assert property (@(posedge clk) disable iff (reset)
      eval_valid && !clear_eval |=> eval_valid)
      else
      begin
         failures++;
         $error("eval_valid dropped without clear_eval");
      end

   clear_drops_valid: assert property (@(posedge clk) disable iff (reset)
      clear_eval && eval_valid |=> !eval_valid)
      else
      begin
         failures++;
         $error("eval_valid still high after clear_eval");
      end

endmodule

bind evaluate evaluate_checker u_checker (
   .clk(clk),
   .reset(reset),
   .clear_eval(clear_eval),
   .eval_valid(eval_valid),
   .eval(eval));

`default_nettype wire

// File: testbench/evaluate_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "eval_defines.svh"

module evaluate_tb;

   import chess_pkg::*;
   import eval_pkg::*;

   logic        clk;
   logic        reset;
   logic        board_valid;
   board_t      board_in;
   logic        clear_eval;
   score_t      eval;
   logic        eval_valid;
   material_t   material;
   logic        insufficient_material;
   logic [31:0] lfsr = 32'hbb66;

   evaluate uut (
      .clk(clk), .reset(reset), .board_valid(board_valid), .board_in(board_in),
      .clear_eval(clear_eval), .eval(eval), .eval_valid(eval_valid), .material(material),
      .insufficient_material(insufficient_material));

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Bound handshake assertions count their failures in the checker
   always @(uut.u_checker.failures)
   begin
      if (uut.u_checker.failures != 0)
      begin
         $display("A bound handshake assertion failed");
         $display("RESULT: FAIL");
         $fatal(1, "Assertion failure");
      end
   end

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   task automatic take_bits(input int n, output int v);
      v = 0;
      for (int i = 0; i < n; i++)
      begin
         v = (v << 1) | int'(lfsr[0]);             // One step per bit
         lfsr = lfsr_step(lfsr);
      end
   endtask

   function automatic int piece_value(input int kind, input bit endgame);
      case (kind)
         `PAWN:   return endgame ? `EG_PAWN : `MG_PAWN;
         `KNIGHT: return endgame ? `EG_KNIGHT : `MG_KNIGHT;
         `BISHOP: return endgame ? `EG_BISHOP : `MG_BISHOP;
         `ROOK:   return endgame ? `EG_ROOK : `MG_ROOK;
         `QUEEN:  return endgame ? `EG_QUEEN : `MG_QUEEN;
         default: return 0;                        // Kings carry no material
      endcase
   endfunction

   // Taper by phase, divide by 62 through the reciprocal, truncate toward zero
   function automatic longint blend(input longint mg, input longint eg, input longint phase);
      return (mg * phase + eg * (`PHASE_MAX - phase)) * `PHASE_RECIP / (1 << `PHASE_SHIFT);
   endfunction

   function automatic board_t with_piece(input board_t b, input int sq, input int code);
      board_t r;
      r = b;
      r[sq*4 +: 4] = 4'(code);
      return r;
   endfunction

   task automatic model(input board_t b, output longint exp_eval, output longint exp_mat,
                        output longint exp_insuf);
      int     count [2][8];
      int     kind;
      int     occupied;
      longint mg;
      longint eg;
      for (int t = 0; t < 8; t++)
      begin
         count[0][t] = 0;
         count[1][t] = 0;
      end
      occupied = 0;
      mg = 0;
      eg = 0;
      for (int sq = 0; sq < `SQUARE_COUNT; sq++)
      begin
         kind = b[sq*4 +: 3];
         if (kind >= `PAWN && kind <= `KING)
         begin
            occupied++;
            count[b[sq*4 + `COLOR_BIT]][kind]++;
         end
      end
      for (int t = `PAWN; t <= `QUEEN; t++)
      begin
         mg += (count[0][t] - count[1][t]) * piece_value(t, 1'b0);
         eg += (count[0][t] - count[1][t]) * piece_value(t, 1'b1);
      end
      exp_eval  = blend(mg, eg, (occupied > `PHASE_MAX) ? `PHASE_MAX : occupied);
      exp_mat   = mg;
      exp_insuf = (count[0][`PAWN] + count[1][`PAWN] + count[0][`ROOK] + count[1][`ROOK] +
                   count[0][`QUEEN] + count[1][`QUEEN] == 0) &&
                  (count[0][`KNIGHT] + count[0][`BISHOP] <= 1) &&
                  (count[1][`KNIGHT] + count[1][`BISHOP] <= 1);
   endtask

   task automatic compare(input string name, input logic signed [63:0] got,
                          input logic signed [63:0] exp);
      if (got !== exp)
      begin
         $display("ERR %s got %h expected %h", name, got, exp);
         $display("RESULT: FAIL");
         $fatal(1, "Mismatch on %s", name);
      end
   endtask

   task automatic wait_valid(input logic level, input int limit);
      int cycles;
      cycles = 0;
      while (eval_valid !== level)
      begin
         @(negedge clk);
         cycles++;
         if (cycles > limit)
         begin
            $display("Timed out after %0d cycles waiting for eval_valid to be %0b",
                     limit, level);
            $display("RESULT: FAIL");
            $fatal(1, "Timeout");
         end
      end
   endtask

   // Called on a falling edge, returns with the result on display
   task automatic evaluate_board(input board_t b);
      longint exp_eval;
      longint exp_mat;
      longint exp_insuf;
      model(b, exp_eval, exp_mat, exp_insuf);
      board_in    = b;
      board_valid = 1'b1;
      @(negedge clk);
      board_valid = 1'b0;
      wait_valid(1'b1, 20);
      compare("eval", eval, exp_eval);
      compare("material", material, exp_mat);
      compare("insufficient_material", insufficient_material, exp_insuf);
   endtask

   task automatic clear_result;
      clear_eval = 1'b1;
      @(negedge clk);
      clear_eval = 1'b0;
      wait_valid(1'b0, 4);
      repeat (2) @(negedge clk);                   // Decode frees one edge after done
   endtask

   task automatic random_board(output board_t b);
      int density;
      int roll;
      int kind;
      int color;
      take_bits(2, density);                       // 0 sparse up to 3 nearly full
      for (int sq = 0; sq < `SQUARE_COUNT; sq++)
      begin
         take_bits(2, roll);
         take_bits(3, kind);
         take_bits(1, color);
         if (roll > density || kind > `KING)
            kind = `EMPTY;
         b[sq*4 +: 4] = {color[0], kind[2:0]};
      end
   endtask

   task automatic start_position_is_even;
      int     rank [8] = '{`ROOK, `KNIGHT, `BISHOP, `QUEEN, `KING, `BISHOP, `KNIGHT, `ROOK};
      board_t b;
      b = '0;
      for (int f = 0; f < 8; f++)
      begin
         b = with_piece(b, f, rank[f]);
         b = with_piece(b, 8 + f, `PAWN);
         b = with_piece(b, 48 + f, `PAWN + 8);
         b = with_piece(b, 56 + f, rank[f] + 8);
      end
      evaluate_board(b);
      compare("eval", eval, 0);
      compare("material", material, 0);
      compare("insufficient_material", insufficient_material, 0);
      clear_result();
   endtask

   task automatic check_endgame(input board_t b, input logic expected);
      evaluate_board(b);
      compare("insufficient_material", insufficient_material, expected);
      clear_result();
   endtask

   task automatic endgame_flags;
      board_t kings;
      kings = with_piece(with_piece('0, 4, `KING), 60, `KING + 8);
      evaluate_board(kings);
      compare("eval", eval, blend(0, 0, 2));
      clear_result();
      check_endgame(kings, 1'b1);
      check_endgame(with_piece(kings, 2, `BISHOP), 1'b1);
      check_endgame(with_piece(with_piece(kings, 1, `KNIGHT), 58, `BISHOP + 8), 1'b1);
      check_endgame(with_piece(kings, 0, `ROOK), 1'b0);
      check_endgame(with_piece(kings, 12, `PAWN), 1'b0);
   endtask

   // Ten white queens and 54 kings fill every square
   task automatic phase_cap;
      board_t b;
      for (int sq = 0; sq < `SQUARE_COUNT; sq++)
         b = with_piece(b, sq, (sq < 10) ? `QUEEN : `KING + 8 * (sq % 2));
      evaluate_board(b);
      compare("eval", eval, blend(10 * `MG_QUEEN, 10 * `EG_QUEEN, 62));
      clear_result();
   endtask

   task automatic handshake_timing;
      score_t held;
      board_in    = with_piece(with_piece(with_piece('0, 4, `KING), 60, `KING + 8), 3, `QUEEN);
      board_valid = 1'b1;                          // Sampled at the next rising edge
      for (int c = 0; c <= 6; c++)
      begin
         @(negedge clk);
         compare("eval_valid", eval_valid, c == 6);
      end
      compare("eval", eval, blend(`MG_QUEEN, `EG_QUEEN, 3));
      held = eval;
      repeat (5)
      begin
         @(negedge clk);
         compare("eval_valid", eval_valid, 1);
         compare("eval", eval, held);
      end
      clear_eval = 1'b1;                           // board_valid still high
      @(negedge clk);
      clear_eval = 1'b0;
      repeat (10)
      begin
         compare("eval_valid", eval_valid, 0);
         @(negedge clk);
      end
      board_valid = 1'b0;
      repeat (2) @(negedge clk);
   endtask

   initial
   begin
      board_t b;
      reset       = 1'b1;
      board_valid = 1'b0;
      board_in    = '0;
      clear_eval  = 1'b0;
      repeat (4) @(negedge clk);
      reset = 1'b0;
      compare("eval_valid", eval_valid, 0);
      start_position_is_even();
      for (int n = 0; n < 40; n++)
      begin
         random_board(b);
         evaluate_board(b);
         clear_result();
      end
      endgame_flags();
      phase_cap();
      handshake_timing();
      if (uut.u_checker.failures == 0)
      begin
         $display("RESULT: PASS");
         $finish;
      end
      else
      begin
         $display("RESULT: FAIL");
         $fatal(1, "Handshake assertion failed");
      end
   end

endmodule

`default_nettype wire

// File: evaluate.f
+incdir+hw
hw/chess_pkg.sv
hw/eval_pkg.sv
hw/board_decode.sv
hw/material_execute.sv
hw/taper_result.sv
hw/evaluate.sv
testbench/evaluate_checker.sv
testbench/evaluate_tb.sv

// File: Bender.yml
package:
  name: evaluate

sources:
  - include_dirs:
      - hw
    files:
      - hw/chess_pkg.sv
      - hw/eval_pkg.sv
      - hw/board_decode.sv
      - hw/material_execute.sv
      - hw/taper_result.sv
      - hw/evaluate.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/evaluate_checker.sv
      - testbench/evaluate_tb.sv
